// File: bitonic_stage.sv
`timescale 1ns/1ps

module bitonic_stage #(
   parameter int KEY_W = merge_pkg::KEY_W_DEFAULT
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_stall,
   input  logic             i_switch,
   input  logic [KEY_W-1:0] i_top,
   input  logic [KEY_W-1:0] i_elem_0,
   input  logic [KEY_W-1:0] i_elem_1,
   output logic [KEY_W-1:0] o_elem_0,
   output logic [KEY_W-1:0] o_elem_1,
   output logic [KEY_W-1:0] o_top,
   output logic             o_switch,
   output logic             o_stall
);

   logic             swap;
   logic [KEY_W-1:0] lo;
   logic [KEY_W-1:0] hi;

   assign swap = (i_elem_1 < i_elem_0);
   assign lo   = swap ? i_elem_1 : i_elem_0;   // Smaller to port 0
   assign hi   = swap ? i_elem_0 : i_elem_1;

   // A stalled input is a bubble, so the held pair is never written out
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_stall  <= 1'b1;
         o_switch <= 1'b0;
      end else begin
         o_stall <= i_stall;
         if (!i_stall) begin
            o_switch <= i_switch;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_stall) begin
         o_elem_0 <= lo;
         o_elem_1 <= hi;
         o_top    <= i_top;   // Newest key rides along
      end
   end

endmodule

// File: merge_control.sv
`timescale 1ns/1ps

module merge_control #(
   parameter int KEY_W      = merge_pkg::KEY_W_DEFAULT,
   parameter int FIFO_DEPTH = merge_pkg::FIFO_DEPTH_DEFAULT
) (
   input  logic                            i_clk,
   input  logic                            i_arst_n,
   input  logic [KEY_W-1:0]                i_a_head,
   input  logic [KEY_W-1:0]                i_b_head,
   input  logic                            i_a_empty,
   input  logic                            i_b_empty,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] i_out_free,
   output merge_pkg::sel_e                 o_sel,
   output logic                            o_stall,
   output logic                            o_switch,
   output logic                            o_a_deq,
   output logic                            o_b_deq
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic             a_end;
   logic             b_end;
   logic             both_end;
   logic             a_le_b;
   logic             heads_ok;
   logic             room;
   logic [2:0]       issued;   // Keys now in key reg, s1 and s2
   logic [CNT_W-1:0] need;

   assign a_end    = (i_a_head == KEY_W'(merge_pkg::RUN_END));
   assign b_end    = (i_b_head == KEY_W'(merge_pkg::RUN_END));
   assign both_end = a_end & b_end;
   assign a_le_b   = (i_a_head <= i_b_head);

   // A zero head ranks above every key
   always_comb begin
      if (a_end && !b_end) begin
         o_sel = merge_pkg::SEL_B;   // Drain B once the A run is done
      end else if (b_end && !a_end) begin
         o_sel = merge_pkg::SEL_A;
      end else if (a_le_b) begin
         o_sel = merge_pkg::SEL_A;   // Ties go to A
      end else begin
         o_sel = merge_pkg::SEL_B;
      end
   end

   // Both heads are needed to decide, even when one side has ended.
   // The output buffer must take the new key plus everything in flight.
   assign heads_ok = ~i_a_empty & ~i_b_empty;
   assign need     = CNT_W'(1) + CNT_W'(issued[0]) + CNT_W'(issued[1])
                   + CNT_W'(issued[2]);
   assign room     = (i_out_free >= need);
   assign o_stall  = ~heads_ok | ~room;

   // Larger output carries the newest key, smaller the terminator
   assign o_switch = ~both_end;

   // Terminator pair is consumed from both sides in one cycle
   assign o_a_deq = ~o_stall & ((o_sel == merge_pkg::SEL_A) | both_end);
   assign o_b_deq = ~o_stall & ((o_sel == merge_pkg::SEL_B) | both_end);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         issued <= '0;
      end else begin
         issued <= {issued[1:0], ~o_stall};
      end
   end

endmodule

// File: merge_fifo.sv
`timescale 1ns/1ps

module merge_fifo #(
   parameter int KEY_W      = merge_pkg::KEY_W_DEFAULT,
   parameter int FIFO_DEPTH = merge_pkg::FIFO_DEPTH_DEFAULT
) (
   input  logic                            i_clk,
   input  logic                            i_arst_n,
   input  logic                            i_enq,
   input  logic                            i_deq,
   input  logic [KEY_W-1:0]                i_data,
   output logic [KEY_W-1:0]                o_data,
   output logic                            o_empty,
   output logic                            o_full,
   output logic [$clog2(FIFO_DEPTH+1)-1:0] o_free
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [KEY_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_enq;
   logic             do_deq;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         return '0;   // Wrap for any depth
      end
      return ptr + 1'b1;
   endfunction

   assign do_enq = i_enq & ~o_full;    // Write to a full buffer is dropped
   assign do_deq = i_deq & ~o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(FIFO_DEPTH));
   assign o_free  = CNT_W'(FIFO_DEPTH) - count;
   assign o_data  = mem[rd_ptr];       // Head word always visible

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_deq) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or both at once
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

endmodule

// File: merge_pkg.sv
package merge_pkg;

   localparam int KEY_W_DEFAULT      = 32;   // Key width
   localparam int FIFO_DEPTH_DEFAULT = 16;   // Entries per buffer

   // A zero key closes a run; real keys are always nonzero
   localparam logic [KEY_W_DEFAULT-1:0] RUN_END = '0;

   typedef enum logic {
      SEL_A = 1'b0,   // Take from buffer A
      SEL_B = 1'b1    // Take from buffer B
   } sel_e;

endpackage

// File: run_merger.f
merge_pkg.sv
merge_fifo.sv
merge_control.sv
bitonic_stage.sv
run_merger.sv
run_merger_checker.sv
run_merger_tb.sv

// File: run_merger.sv
`timescale 1ns/1ps

module run_merger #(
   parameter int KEY_W      = merge_pkg::KEY_W_DEFAULT,
   parameter int FIFO_DEPTH = merge_pkg::FIFO_DEPTH_DEFAULT
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic [KEY_W-1:0] i_in_a_data,
   input  logic             i_in_a_empty,
   input  logic [KEY_W-1:0] i_in_b_data,
   input  logic             i_in_b_empty,
   output logic             o_in_a_read,
   output logic             o_in_b_read,
   input  logic             i_out_ready,
   output logic             o_out_write,
   output logic [KEY_W-1:0] o_out_data
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [KEY_W-1:0] a_head;
   logic [KEY_W-1:0] b_head;
   logic             a_empty;
   logic             b_empty;
   logic             a_full;
   logic             b_full;
   logic             c_empty;
   logic [CNT_W-1:0] c_free;

   merge_pkg::sel_e  ctrl_sel;
   logic             ctrl_stall;
   logic             ctrl_switch;
   logic             a_deq;
   logic             b_deq;

   logic [KEY_W-1:0] r_a;          // Last key taken from A
   logic [KEY_W-1:0] r_b;          // Last key taken from B
   logic [KEY_W-1:0] r_top;        // Newest key
   logic             key_stall;
   logic             key_switch;

   logic [KEY_W-1:0] s1_hi;
   logic [KEY_W-1:0] s1_top;
   logic             s1_switch;
   logic             s1_stall;
   logic [KEY_W-1:0] s2_lo;
   logic [KEY_W-1:0] s2_hi;
   logic             s2_switch;
   logic             s2_stall;

   logic [KEY_W-1:0] c_wdata;
   logic             c_enq;
   logic             ready_q;

   // Upstream word is taken on the same edge as the read strobe
   assign o_in_a_read = ~i_in_a_empty & ~a_full;
   assign o_in_b_read = ~i_in_b_empty & ~b_full;

   merge_fifo #(.KEY_W(KEY_W), .FIFO_DEPTH(FIFO_DEPTH)) buf_a (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_enq    (o_in_a_read),
      .i_deq    (a_deq),
      .i_data   (i_in_a_data),
      .o_data   (a_head),
      .o_empty  (a_empty),
      .o_full   (a_full),
      .o_free   ()
   );

   merge_fifo #(.KEY_W(KEY_W), .FIFO_DEPTH(FIFO_DEPTH)) buf_b (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_enq    (o_in_b_read),
      .i_deq    (b_deq),
      .i_data   (i_in_b_data),
      .o_data   (b_head),
      .o_empty  (b_empty),
      .o_full   (b_full),
      .o_free   ()
   );

   merge_control #(.KEY_W(KEY_W), .FIFO_DEPTH(FIFO_DEPTH)) ctrl (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_a_head   (a_head),
      .i_b_head   (b_head),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_out_free (c_free),
      .o_sel      (ctrl_sel),
      .o_stall    (ctrl_stall),
      .o_switch   (ctrl_switch),
      .o_a_deq    (a_deq),
      .o_b_deq    (b_deq)
   );

   // Terminator dequeues both zero heads, which clears r_a and r_b for the next run
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         r_a        <= '0;
         r_b        <= '0;
         r_top      <= '0;
         key_stall  <= 1'b1;
         key_switch <= 1'b0;
      end else begin
         key_stall <= ctrl_stall;
         if (!ctrl_stall) begin
            key_switch <= ctrl_switch;
            r_top      <= (ctrl_sel == merge_pkg::SEL_A) ? a_head : b_head;
         end
         if (a_deq) begin
            r_a <= a_head;
         end
         if (b_deq) begin
            r_b <= b_head;
         end
      end
   end

   bitonic_stage #(.KEY_W(KEY_W)) net_s1 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_stall  (key_stall),
      .i_switch (key_switch),
      .i_top    (r_top),
      .i_elem_0 (r_a),
      .i_elem_1 (r_b),
      .o_elem_0 (),
      .o_elem_1 (s1_hi),
      .o_top    (s1_top),
      .o_switch (s1_switch),
      .o_stall  (s1_stall)
   );

   // Second pair is the newest key against the larger of the last two
   bitonic_stage #(.KEY_W(KEY_W)) net_s2 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_stall  (s1_stall),
      .i_switch (s1_switch),
      .i_top    (s1_top),
      .i_elem_0 (s1_top),
      .i_elem_1 (s1_hi),
      .o_elem_0 (s2_lo),
      .o_elem_1 (s2_hi),
      .o_top    (),
      .o_switch (s2_switch),
      .o_stall  (s2_stall)
   );

   assign c_wdata = s2_switch ? s2_hi : s2_lo;
   assign c_enq   = ~s2_stall;   // Room was reserved at issue

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   assign o_out_write = ready_q & ~c_empty;

   merge_fifo #(.KEY_W(KEY_W), .FIFO_DEPTH(FIFO_DEPTH)) buf_c (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_enq    (c_enq),
      .i_deq    (o_out_write),
      .i_data   (c_wdata),
      .o_data   (o_out_data),
      .o_empty  (c_empty),
      .o_full   (),
      .o_free   (c_free)
   );

endmodule

// File: run_merger_checker.sv
`timescale 1ns/1ps

module run_merger_checker #(
   parameter int KEY_W = merge_pkg::KEY_W_DEFAULT
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_out_ready,
   input  logic             i_out_write,
   input  logic [KEY_W-1:0] i_out_data,
   output logic [15:0]      o_done,
   output logic [15:0]      o_errors
);

   logic [31:0]      gold [512];
   logic [KEY_W-1:0] exp_q [$];
   int               test_len [$];
   int               got;
   int               test_err;
   logic             ready_prev;

   // Pull only the expected keys out of each record
   initial begin : load_expected
      int ptr;
      int na;
      int nb;
      int ne;
      $readmemh("run_merger_golden.txt", gold);
      ptr = 1;
      for (int t = 0; t < int'(gold[0]); t++) begin
         na = int'(gold[ptr]);
         nb = int'(gold[ptr+1]);
         ne = int'(gold[ptr+2]);
         ptr = ptr + 4 + na + nb;
         for (int i = 0; i < ne; i++) begin
            exp_q.push_back(gold[ptr+i][KEY_W-1:0]);
         end
         ptr = ptr + ne;
         test_len.push_back(ne);
      end
      got        = 0;
      test_err   = 0;
      ready_prev = 1'b0;
      o_done     = '0;
      o_errors   = '0;
   end

   always @(posedge i_clk) begin : compare
      if (!i_arst_n) begin
         ready_prev = 1'b0;
      end else begin
         if (i_out_write) begin
            if (!ready_prev) begin   // ready was low a cycle ago
               $display("test %0d: write issued more than one cycle after ready fell", o_done + 1);
               test_err++;
               o_errors++;
            end
            if (exp_q.size() == 0) begin
               $display("unexpected write of %h after all expected keys", i_out_data);
               o_errors++;
            end else begin
               if (i_out_data !== exp_q[0]) begin
                  $display("ERR o_out_data got %h expected %h (test %0d key %0d)",
                           i_out_data, exp_q[0], o_done + 1, got);
                  test_err++;
                  o_errors++;
               end
               exp_q.delete(0);
               got++;
               if (got == test_len[0]) begin
                  $display("test %0d: %0d keys, %0d errors, %s", o_done + 1, got, test_err,
                           (test_err == 0) ? "ok" : "failed");
                  test_len.delete(0);
                  got      = 0;
                  test_err = 0;
                  o_done++;
               end
            end
         end
         ready_prev = i_out_ready;
      end
   end

endmodule

// File: run_merger_golden.txt
// Per record: count A, count B, count expected, mode (bit0 random ready, bit1 starved inputs)
// then the A keys, the B keys and the expected output keys; first word is the record count
6
// Interleaved runs
5 5 9 0
03 08 0f 14 00
05 09 0c 1e 00
03 05 08 09 0c 0f 14 1e 00
// Equal keys, then an empty run on A
5 7 a 0
07 07 0a 00 00
07 0a 0a 00 20 21 00
07 07 07 0a 0a 0a 00 20 21 00
// Three run pairs back to back
9 7 d 0
01 04 00 10 00 02 03 06 00
02 00 11 12 00 05 00
01 02 04 00 10 11 12 00 02 03 05 06 00
// Random back-pressure
a c 15 1
02 05 06 0b 0d 11 18 19 22 00
01 03 07 08 0c 10 14 1a 1b 25 28 00
01 02 03 05 06 07 08 0b 0c 0d 10 11 14 18 19 1a
1b 22 25 28 00
// Starved inputs, second run empty on B
6 5 9 2
04 09 0e 00 01 00
06 07 10 00 00
04 06 07 09 0e 10 00 01 00
// Starved inputs with back-pressure
4 4 7 3
0a 0b 0c 00
0a 0b 0c 00
0a 0a 0b 0b 0c 0c 00

// File: run_merger_tb.sv
`timescale 1ns/1ps

module run_merger_tb;

   localparam int KEY_W      = merge_pkg::KEY_W_DEFAULT;
   localparam int FIFO_DEPTH = merge_pkg::FIFO_DEPTH_DEFAULT;
   localparam int WAIT_LIMIT = 4000;   // Cycles per test

   logic             clk;
   logic             arst_n;
   logic [KEY_W-1:0] in_a_data;
   logic             in_a_empty;
   logic [KEY_W-1:0] in_b_data;
   logic             in_b_empty;
   logic             in_a_read;
   logic             in_b_read;
   logic             out_ready;
   logic             out_write;
   logic [KEY_W-1:0] out_data;
   logic [15:0]      done_count;
   logic [15:0]      chk_errors;

   logic [31:0]      gold [512];
   logic [KEY_W-1:0] qa [$];           // Upstream FIFO A contents
   logic [KEY_W-1:0] qb [$];
   logic             rand_ready;
   logic             starve;
   logic [15:0]      lfsr;
   int               tb_errors;

   run_merger #(.KEY_W(KEY_W), .FIFO_DEPTH(FIFO_DEPTH)) uut (
      .i_clk        (clk),
      .i_arst_n     (arst_n),
      .i_in_a_data  (in_a_data),
      .i_in_a_empty (in_a_empty),
      .i_in_b_data  (in_b_data),
      .i_in_b_empty (in_b_empty),
      .o_in_a_read  (in_a_read),
      .o_in_b_read  (in_b_read),
      .i_out_ready  (out_ready),
      .o_out_write  (out_write),
      .o_out_data   (out_data)
   );

   run_merger_checker #(.KEY_W(KEY_W)) chk (
      .i_clk       (clk),
      .i_arst_n    (arst_n),
      .i_out_ready (out_ready),
      .i_out_write (out_write),
      .i_out_data  (out_data),
      .o_done      (done_count),
      .o_errors    (chk_errors)
   );

   function automatic logic [15:0] next_lfsr(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Upstream FIFOs and downstream ready
   always @(posedge clk) begin : drive
      logic a_gap;
      logic b_gap;
      a_gap = 1'b0;
      b_gap = 1'b0;
      if (in_a_read && qa.size() > 0) begin
         qa.delete(0);   // Word taken on this edge
      end
      if (in_b_read && qb.size() > 0) begin
         qb.delete(0);
      end
      if (starve) begin
         a_gap = lfsr[0];
         lfsr  = next_lfsr(lfsr);
         b_gap = lfsr[0];
         lfsr  = next_lfsr(lfsr);
      end
      if (rand_ready) begin
         out_ready <= lfsr[0];
         lfsr = next_lfsr(lfsr);
      end else begin
         out_ready <= 1'b1;
      end
      in_a_empty <= (qa.size() == 0) || a_gap;
      in_b_empty <= (qb.size() == 0) || b_gap;
      if (qa.size() > 0 && !a_gap) begin
         in_a_data <= qa[0];
      end else begin
         in_a_data <= '0;   // Nothing valid while empty
      end
      if (qb.size() > 0 && !b_gap) begin
         in_b_data <= qb[0];
      end else begin
         in_b_data <= '0;
      end
   end

   initial begin : run_tests
      int ptr;
      int na;
      int nb;
      int ne;
      int waited;
      int reset_err;
      int num_tests;
      logic [31:0] mode;
      arst_n     = 1'b0;
      in_a_data  = '0;
      in_b_data  = '0;
      in_a_empty = 1'b1;
      in_b_empty = 1'b1;
      out_ready  = 1'b0;
      rand_ready = 1'b0;
      starve     = 1'b0;
      lfsr       = 16'd28626;
      tb_errors  = 0;
      reset_err  = 0;
      $readmemh("run_merger_golden.txt", gold);
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // Nothing may move while idle after reset
      repeat (10) begin
         @(negedge clk);
         if (out_write || in_a_read || in_b_read) begin
            reset_err++;
         end
      end
      $display("reset test: %s", (reset_err == 0) ? "ok" : "strobe active with no input");
      tb_errors = tb_errors + reset_err;

      num_tests = int'(gold[0]);
      ptr = 1;
      for (int t = 0; t < num_tests; t++) begin
         @(negedge clk);
         na   = int'(gold[ptr]);
         nb   = int'(gold[ptr+1]);
         ne   = int'(gold[ptr+2]);
         mode = gold[ptr+3];
         ptr  = ptr + 4;
         rand_ready = mode[0];
         starve     = mode[1];
         for (int i = 0; i < na; i++) begin
            qa.push_back(gold[ptr+i][KEY_W-1:0]);
         end
         ptr = ptr + na;
         for (int i = 0; i < nb; i++) begin
            qb.push_back(gold[ptr+i][KEY_W-1:0]);
         end
         ptr = ptr + nb + ne;
         waited = 0;
         while (int'(done_count) < t + 1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (int'(done_count) < t + 1) begin
            $display("test %0d: timed out waiting for %0d output keys", t + 1, ne);
            tb_errors++;
            break;
         end
      end

      // Let any stray write reach the checker
      rand_ready = 1'b0;
      starve     = 1'b0;
      repeat (20) @(negedge clk);
      $display("tests done %0d of %0d, checker errors %0d, other failures %0d",
               done_count, num_tests, chk_errors, tb_errors);
      if (tb_errors == 0 && chk_errors == 0 && int'(done_count) == num_tests) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the run_merger testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module run_merger_tb -f run_merger.f -o run_merger_sim \
   && ./obj_dir/run_merger_sim > sim.log 2>&1 \
   || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qxF '** PASS **' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
